// ==== hw/mem_tile_cfg_pkg.sv ====
////////////////////
// Memory tile geometry
// Bank and row layout of the SRAM macros and the address split
////////////////////

package mem_tile_cfg_pkg;

  localparam int unsigned WordWidth       = 64;
  localparam int unsigned SramDataWidth   = 32;
  localparam int unsigned NumBanksPerWord = WordWidth / SramDataWidth;
  localparam int unsigned NumBankRows     = 4;
  localparam int unsigned SramNumWords    = 64;

  // Address field widths, low to high
  localparam int unsigned SramByteOffsetWidth = $clog2(SramDataWidth / 8);
  localparam int unsigned SramBankSelWidth    = $clog2(NumBanksPerWord);
  localparam int unsigned SramAddrWidth       = $clog2(SramNumWords);
  localparam int unsigned SramMacroSelWidth   = $clog2(NumBankRows);
  localparam int unsigned AddrWidth = SramMacroSelWidth + SramAddrWidth + SramBankSelWidth +
                                      SramByteOffsetWidth;

  typedef logic [WordWidth-1:0]         word_t;
  typedef logic [WordWidth/8-1:0]       strb_t;
  typedef logic [SramDataWidth-1:0]     sram_data_t;
  typedef logic [SramDataWidth/8-1:0]   sram_strb_t;
  typedef logic [SramAddrWidth-1:0]     sram_addr_t;
  typedef logic [SramMacroSelWidth-1:0] macro_sel_t;

  typedef struct packed {
    macro_sel_t                     macro_sel;
    sram_addr_t                     sram_addr;
    logic [SramBankSelWidth-1:0]    bank_sel;
    logic [SramByteOffsetWidth-1:0] byte_off;
  } mem_addr_fields_t;

  // Flat byte address or decoded fields
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    mem_addr_fields_t     fields;
  } mem_addr_u;

endpackage

// ==== hw/mem_tile_link_pkg.sv ====
////////////////////
// Memory tile link flits
// Request and response flits of the credit-based links
////////////////////

package mem_tile_link_pkg;

  localparam int unsigned IdWidth = 4;

  typedef logic [IdWidth-1:0] id_t;

  // Wide-word request as seen on the request link
  typedef struct packed {
    logic                        valid;
    logic                        we;
    id_t                         id;
    mem_tile_cfg_pkg::mem_addr_u addr;
    mem_tile_cfg_pkg::word_t     wdata;
    mem_tile_cfg_pkg::strb_t     be;
  } mem_req_flit_t;

  // Writes return zero data
  typedef struct packed {
    logic                    valid;
    logic                    we;
    id_t                     id;
    mem_tile_cfg_pkg::word_t rdata;
  } mem_rsp_flit_t;

  // Holds credit counts up to 15
  typedef logic [3:0] credit_cnt_t;

endpackage

// ==== hw/sram_macro.sv ====
////////////////////
// SRAM macro
// Single port, byte enables, one cycle read latency
////////////////////

`timescale 1ns/1ps

module sram_macro
  import mem_tile_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       req_i,
  input  logic       we_i,
  input  sram_addr_t addr_i,
  input  sram_data_t wdata_i,
  input  sram_strb_t be_i,
  output sram_data_t rdata_o
);

  sram_data_t mem_q [SramNumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes change
        for (int b = 0; b < SramDataWidth / 8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8+:8] <= wdata_i[b*8+:8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== hw/mem_bank_array.sv ====
////////////////////
// Memory bank array
// Splits each wide word over the banks of one macro row
// and rebuilds the read word from the registered row select
////////////////////

`timescale 1ns/1ps

module mem_bank_array
  import mem_tile_cfg_pkg::*;
  import mem_tile_link_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  mem_req_flit_t issue_i,
  output word_t         rdata_o
);

  mem_addr_fields_t addr_fields;
  logic             read_issue;
  macro_sel_t       row_sel_q;

  logic       [NumBankRows-1:0]                      row_en;
  sram_data_t [NumBankRows-1:0][NumBanksPerWord-1:0] row_rdata;

  // Bank select and byte offset carry no steering, addresses are word aligned
  assign addr_fields = issue_i.addr.fields;
  assign read_issue  = issue_i.valid && !issue_i.we;

  for (genvar j = 0; j < NumBankRows; j++) begin : gen_row_en
    assign row_en[j] = issue_i.valid && (addr_fields.macro_sel == macro_sel_t'(j));
  end

  // Row of the last read, used when its data comes out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      row_sel_q <= '0;
    end else if (read_issue) begin
      row_sel_q <= addr_fields.macro_sel;
    end
  end

  ////////////////////
  // Macro grid
  ////////////////////

  for (genvar i = 0; i < NumBanksPerWord; i++) begin : gen_banks
    for (genvar j = 0; j < NumBankRows; j++) begin : gen_rows
      sram_macro u_macro (
        .clk_i   (clk_i),
        .req_i   (row_en[j]),
        .we_i    (issue_i.we),
        .addr_i  (addr_fields.sram_addr),
        .wdata_i (issue_i.wdata[i*SramDataWidth+:SramDataWidth]),
        .be_i    (issue_i.be[i*SramDataWidth/8+:SramDataWidth/8]),
        .rdata_o (row_rdata[j][i])
      );
    end
    assign rdata_o[i*SramDataWidth+:SramDataWidth] = row_rdata[row_sel_q][i];
  end

  // An issued request addresses a whole wide word
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_i.valid |-> (addr_fields.bank_sel == '0) && (addr_fields.byte_off == '0));

endmodule

// ==== hw/mem_req_ingress.sv ====
////////////////////
// Request ingress
// Credit-granting request buffer, one issue per cycle
////////////////////

`timescale 1ns/1ps

module mem_req_ingress
  import mem_tile_link_pkg::*;
#(
  parameter int unsigned NumReqCredits = 4
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  mem_req_flit_t req_i,
  output logic          req_credit_o,
  input  logic          can_issue_i,
  output mem_req_flit_t issue_o
);

  localparam int unsigned PtrWidth = (NumReqCredits > 1) ? $clog2(NumReqCredits) : 1;

  mem_req_flit_t        buf_q [NumReqCredits];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  credit_cnt_t          fill_q;
  logic                 push;
  logic                 pop;

  assign push = req_i.valid;
  assign pop  = (fill_q != '0) && can_issue_i;

  // Head goes out on the cycle it is popped, its slot is credited back
  always_comb begin
    issue_o       = buf_q[rd_ptr_q];
    issue_o.valid = pop;
  end
  assign req_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(NumReqCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(NumReqCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // Sender pushed without holding a credit
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.valid |-> (fill_q < credit_cnt_t'(NumReqCredits)));

endmodule

// ==== hw/mem_rsp_egress.sv ====
////////////////////
// Response egress
// Tracks response credits and forms the response flits
////////////////////

`timescale 1ns/1ps

module mem_rsp_egress
  import mem_tile_cfg_pkg::*;
  import mem_tile_link_pkg::*;
#(
  parameter int unsigned NumRspCredits = 2
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  mem_req_flit_t issue_i,
  output logic          can_issue_o,
  input  word_t         rdata_i,
  input  logic          rsp_credit_i,
  output mem_rsp_flit_t rsp_o
);

  credit_cnt_t credit_cnt_q;
  logic        rsp_valid_q;
  logic        rsp_we_q;
  id_t         rsp_id_q;

  assign can_issue_o = (credit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= credit_cnt_t'(NumRspCredits);
      rsp_valid_q  <= 1'b0;
    end else begin
      rsp_valid_q <= issue_i.valid;
      if (issue_i.valid && !rsp_credit_i) begin
        credit_cnt_q <= credit_cnt_q - 1'b1;
      end else if (rsp_credit_i && !issue_i.valid) begin
        credit_cnt_q <= credit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i.valid) begin
      rsp_we_q <= issue_i.we;
      rsp_id_q <= issue_i.id;
    end
  end

  // Read data arrives from the banks one cycle after the issue
  always_comb begin
    rsp_o.valid = rsp_valid_q;
    rsp_o.we    = rsp_we_q;
    rsp_o.id    = rsp_id_q;
    rsp_o.rdata = rsp_we_q ? '0 : rdata_i;
  end

  // Receiver returned more credits than it was given
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_q <= credit_cnt_t'(NumRspCredits));

endmodule

// ==== hw/mem_tile.sv ====
////////////////////
// Memory tile
// Request buffer, banked SRAM storage and response link
////////////////////

`timescale 1ns/1ps

module mem_tile
  import mem_tile_cfg_pkg::*;
  import mem_tile_link_pkg::*;
#(
  parameter int unsigned NumReqCredits = 4,
  parameter int unsigned NumRspCredits = 2
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  mem_req_flit_t req_i,
  output logic          req_credit_o,
  output mem_rsp_flit_t rsp_o,
  input  logic          rsp_credit_i
);

  mem_req_flit_t issue;
  logic          can_issue;
  word_t         bank_rdata;

  mem_req_ingress #(
    .NumReqCredits (NumReqCredits)
  ) u_ingress (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .can_issue_i  (can_issue),
    .issue_o      (issue)
  );

  mem_bank_array u_banks (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .issue_i (issue),
    .rdata_o (bank_rdata)
  );

  mem_rsp_egress #(
    .NumRspCredits (NumRspCredits)
  ) u_egress (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue_i      (issue),
    .can_issue_o  (can_issue),
    .rdata_i      (bank_rdata),
    .rsp_credit_i (rsp_credit_i),
    .rsp_o        (rsp_o)
  );

endmodule

// ==== bench/tb_mem_tile.sv ====
////////////////////
// Memory tile testbench
// Replays the request patterns over the credit links
// and checks every response in order
////////////////////

`timescale 1ns/1ps

module tb_mem_tile
  import mem_tile_cfg_pkg::*;
  import mem_tile_link_pkg::*;
();

  localparam int NumReqCredits = 4;
  localparam int NumRspCredits = 2;
  localparam int NumPatterns   = 22;
  localparam int TimeoutCycles = 60 * NumPatterns + 200;
  // Window in which the receiver returns no response credits
  localparam int HoldStart     = 30;
  localparam int HoldCycles    = 30;

  logic          clk_i;
  logic          rst_n_i;
  mem_req_flit_t req;
  logic          req_credit;
  mem_rsp_flit_t rsp;
  logic          rsp_credit;

  logic [155:0]  patterns [NumPatterns];
  mem_rsp_flit_t exp_q [$];
  logic          hold_active = 1'b0;
  int            cycle_count = 0;
  int            sent_count = 0;
  int            credit_pulses = 0;
  int            rsp_count = 0;
  int            held_rsp_count = 0;

  mem_tile #(
    .NumReqCredits (NumReqCredits),
    .NumRspCredits (NumRspCredits)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_o        (rsp),
    .rsp_credit_i (rsp_credit)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_response();
    mem_rsp_flit_t exp_rsp;
    if (exp_q.size() == 0) begin
      stop_with_error("A response arrived with no request outstanding");
    end else begin
      exp_rsp = exp_q.pop_front();
      check_value("rsp_o.we", rsp.we, exp_rsp.we);
      check_value("rsp_o.id", rsp.id, exp_rsp.id);
      check_value("rsp_o.rdata", rsp.rdata, exp_rsp.rdata);
    end
  endtask

  // Sends one pattern per cycle while the sender holds a request credit
  task automatic send_requests();
    logic [155:0]  pat;
    mem_rsp_flit_t exp_rsp;
    int            idx;
    idx = 0;
    while (idx < NumPatterns) begin
      req = '0;
      if (sent_count - credit_pulses < NumReqCredits) begin
        pat            = patterns[idx];
        req.valid      = 1'b1;
        req.we         = pat[152];
        req.id         = pat[151:148];
        req.addr.flat  = pat[146:136];
        req.wdata      = pat[135:72];
        req.be         = pat[71:64];
        exp_rsp        = '0;
        exp_rsp.valid  = 1'b1;
        exp_rsp.we     = pat[152];
        exp_rsp.id     = pat[151:148];
        exp_rsp.rdata  = pat[63:0];
        exp_q.push_back(exp_rsp);
        sent_count++;
        idx++;
      end
      @(posedge clk_i);
      #2;
    end
    req = '0;
  endtask

  ////////////////////
  // Receiver
  ////////////////////

  initial begin
    int unsigned wait_cycles;
    int          returned;
    rsp_credit  = 1'b0;
    returned    = 0;
    wait_cycles = $urandom(33191) % 6;
    forever begin
      @(posedge clk_i);
      #2;
      rsp_credit  = 1'b0;
      hold_active = (cycle_count >= HoldStart) && (cycle_count < HoldStart + HoldCycles);
      if (rst_n_i && !hold_active && (returned < rsp_count)) begin
        if (wait_cycles == 0) begin
          rsp_credit  = 1'b1;
          returned++;
          wait_cycles = $urandom_range(5, 0);
        end else begin
          wait_cycles--;
        end
      end
    end
  end

  // Sampled mid-cycle where the DUT outputs are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (req_credit) begin
        credit_pulses++;
      end
      if (rsp.valid) begin
        check_response();
        rsp_count++;
        if (hold_active) begin
          held_rsp_count++;
          if (held_rsp_count > NumRspCredits) begin
            stop_with_error("More responses than response credits while credits were held");
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycle_count, rsp_count, NumPatterns);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  initial begin
    rst_n_i = 1'b0;
    req     = '0;
    $readmemh("bench/mem_tile_patterns.hex", patterns);
    if ($isunknown(patterns[NumPatterns-1])) begin
      stop_with_error("The pattern file could not be read completely");
    end
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    send_requests();
    while (rsp_count < NumPatterns) begin
      @(posedge clk_i);
    end
    // A few idle cycles to catch any extra response
    repeat (5) @(posedge clk_i);
    check_value("req_credit_o pulses", credit_pulses, sent_count);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== bench/mem_tile_patterns.hex ====
// Each line holds we, id, byte address, wdata, be and expected rdata
// Writes expect zero rdata
1_0_008_1122334455667788_FF_0000000000000000
0_1_008_0000000000000000_00_1122334455667788
1_2_010_AAAAAAAAAAAAAAAA_FF_0000000000000000
1_3_010_0123456789ABCDEF_0F_0000000000000000
1_4_010_5500000000000000_80_0000000000000000
1_5_010_0000CC0000DD0000_24_0000000000000000
0_6_010_0000000000000000_00_55AACCAA89DDCDEF
1_7_028_A0A0A0A005050505_FF_0000000000000000
1_8_228_B1B1B1B116161616_FF_0000000000000000
1_9_428_C2C2C2C227272727_FF_0000000000000000
1_A_628_D3D3D3D338383838_FF_0000000000000000
0_B_628_0000000000000000_00_D3D3D3D338383838
0_C_428_0000000000000000_00_C2C2C2C227272727
0_D_228_0000000000000000_00_B1B1B1B116161616
0_E_028_0000000000000000_00_A0A0A0A005050505
1_F_008_DEADBEEF00000000_F0_0000000000000000
0_0_008_0000000000000000_00_DEADBEEF55667788
1_1_7F8_0F1E2D3C4B5A6978_FF_0000000000000000
0_2_7F8_0000000000000000_00_0F1E2D3C4B5A6978
0_3_010_0000000000000000_00_55AACCAA89DDCDEF
0_4_628_0000000000000000_00_D3D3D3D338383838
0_5_028_0000000000000000_00_A0A0A0A005050505

// ==== tb.f ====
hw/mem_tile_cfg_pkg.sv
hw/mem_tile_link_pkg.sv
hw/sram_macro.sv
hw/mem_bank_array.sv
hw/mem_req_ingress.sv
hw/mem_rsp_egress.sv
hw/mem_tile.sv
bench/tb_mem_tile.sv

// ==== Bender.yml ====
package:
  name: mem_tile

sources:
  # Packages first, the flit types depend on the geometry
  - hw/mem_tile_cfg_pkg.sv
  - hw/mem_tile_link_pkg.sv
  - hw/sram_macro.sv
  - hw/mem_bank_array.sv
  - hw/mem_req_ingress.sv
  - hw/mem_rsp_egress.sv
  - hw/mem_tile.sv

  - target: test
    files:
      - bench/tb_mem_tile.sv

# Simulation top: tb_mem_tile
# Design top: mem_tile
